/* kbd_subsystem.f */
rtl/common.sv
rtl/keyboard.sv
rtl/scancode_decoder.sv
rtl/key_fifo.sv
rtl/kbd_subsystem.sv
sim/ps2_device.sv
sim/tb_kbd_subsystem.sv

/* rtl/common.sv */
package common;

    // one byte as it arrives from the device
    typedef logic [7:0] scancode_t;

    // {extended, release, scancode}
    typedef logic [9:0] key_event_t;

    // receiver frame position
    typedef enum logic [1:0] {
        IDLE,
        DATA,
        PARITY,
        STOP
    } kbd_state_t;

    // decoder prefix tracking
    typedef enum logic {
        WAIT_CODE,
        AFTER_PREFIX
    } dec_state_t;

    // prefix bytes of the set 2 scancodes
    localparam scancode_t PREFIX_EXTENDED = 8'hE0;
    localparam scancode_t PREFIX_RELEASE  = 8'hF0;

    // key event queue sizing
    localparam int FIFO_DEPTH = 8;
    localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);

    typedef logic [FIFO_PTR_W-1:0] fifo_ptr_t;
    typedef logic [FIFO_PTR_W:0]   fifo_count_t;

    // stall timeout inside a frame, in clk_i cycles
    localparam int WATCHDOG_CYCLES = 2000;
    localparam int WATCHDOG_W      = $clog2(WATCHDOG_CYCLES + 1);

    typedef logic [WATCHDOG_W-1:0] wdog_count_t;

endpackage

/* rtl/kbd_subsystem.sv */
module kbd_subsystem (
    input  logic               clk_i,
    input  logic               reset_i,
    input  logic               ps2_clk_i,
    input  logic               ps2_data_i,
    input  logic               pop_i,
    output logic               event_valid_o,
    output common::key_event_t event_o,
    output logic               overflow_o,
    output logic               frame_error_o
);
    import common::*;

    logic       kb_ready;
    scancode_t  kb_scancode;
    logic       dec_valid;
    key_event_t dec_event;

    // frame receiver
    keyboard u_keyboard (
        .clk_i            (clk_i),
        .reset_i          (reset_i),
        .clk_kbd_async_i  (ps2_clk_i),
        .kbd_data_async_i (ps2_data_i),
        .ready_o          (kb_ready),
        .scancode_o       (kb_scancode),
        .frame_error_o    (frame_error_o)
    );

    // frame errors also reset the prefix state
    scancode_decoder u_decoder (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .ready_i       (kb_ready),
        .scancode_i    (kb_scancode),
        .frame_error_i (frame_error_o),
        .event_valid_o (dec_valid),
        .event_o       (dec_event)
    );

    key_fifo u_fifo (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .push_i      (dec_valid),
        .push_data_i (dec_event),
        .pop_i       (pop_i),
        .valid_o     (event_valid_o),
        .data_o      (event_o),
        .overflow_o  (overflow_o)
    );

endmodule

/* rtl/key_fifo.sv */
module key_fifo (
    input  logic               clk_i,
    input  logic               reset_i,
    input  logic               push_i,
    input  common::key_event_t push_data_i,
    input  logic               pop_i,
    output logic               valid_o,
    output common::key_event_t data_o,
    output logic               overflow_o
);
    import common::*;

    localparam fifo_count_t FULL_COUNT = (FIFO_PTR_W + 1)'(FIFO_DEPTH);

    key_event_t  mem_r [FIFO_DEPTH];
    fifo_ptr_t   wr_ptr_r;
    fifo_ptr_t   rd_ptr_r;
    fifo_count_t count_r;
    logic        do_pop;
    logic        do_push;

    // empty pops are ignored
    assign do_pop  = pop_i && (count_r != '0);
    // a pop in the same cycle frees the slot on a full queue
    assign do_push = push_i && ((count_r != FULL_COUNT) || do_pop);

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            wr_ptr_r   <= '0;
            rd_ptr_r   <= '0;
            count_r    <= '0;
            overflow_o <= 1'b0;
        end else begin
            if (do_push) begin
                wr_ptr_r <= wr_ptr_r + 1'b1;
            end
            if (do_pop) begin
                rd_ptr_r <= rd_ptr_r + 1'b1;
            end

            case ({do_push, do_pop})
                2'b10:   count_r <= count_r + 1'b1;
                2'b01:   count_r <= count_r - 1'b1;
                default: count_r <= count_r;
            endcase

            // sticky until reset
            if (push_i && !do_push) begin
                overflow_o <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (do_push) begin
            mem_r[wr_ptr_r] <= push_data_i;
        end
    end

    // head shown straight from storage
    assign valid_o = (count_r != '0);
    assign data_o  = mem_r[rd_ptr_r];

endmodule

/* rtl/keyboard.sv */
module keyboard (
    input  logic              clk_i,
    input  logic              reset_i,
    input  logic              clk_kbd_async_i,
    input  logic              kbd_data_async_i,
    output logic              ready_o,
    output common::scancode_t scancode_o,
    output logic              frame_error_o
);
    import common::*;

    localparam wdog_count_t WDOG_LOAD = WATCHDOG_W'(WATCHDOG_CYCLES);

    // two-flop synchronizers, lines idle high
    logic [1:0]  clk_sync_r;
    logic [1:0]  data_sync_r;
    logic        clk_prev_r;
    logic        fall_r;
    logic        data_r;

    kbd_state_t  state_r;
    logic [2:0]  bit_cnt_r;
    scancode_t   shift_r;
    logic        parity_acc_r;
    logic        parity_ok_r;
    wdog_count_t wdog_r;
    logic        wdog_expired;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            clk_sync_r  <= 2'b11;
            data_sync_r <= 2'b11;
            clk_prev_r  <= 1'b1;
            fall_r      <= 1'b0;
        end else begin
            clk_sync_r  <= {clk_sync_r[0], clk_kbd_async_i};
            data_sync_r <= {data_sync_r[0], kbd_data_async_i};
            clk_prev_r  <= clk_sync_r[1];
            // registered strobe, data kept aligned with it
            fall_r      <= clk_prev_r & ~clk_sync_r[1];
        end
        data_r <= data_sync_r[1];
    end

    // device stalled mid-frame
    assign wdog_expired = (state_r != IDLE) && !fall_r && (wdog_r == '0);

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_r       <= IDLE;
            bit_cnt_r     <= '0;
            parity_acc_r  <= 1'b0;
            parity_ok_r   <= 1'b0;
            wdog_r        <= WDOG_LOAD;
            ready_o       <= 1'b0;
            frame_error_o <= 1'b0;
        end else begin
            ready_o       <= 1'b0;
            frame_error_o <= 1'b0;

            // reload on every device clock edge, count down otherwise
            if (state_r == IDLE || fall_r) begin
                wdog_r <= WDOG_LOAD;
            end else if (wdog_r != '0) begin
                wdog_r <= wdog_r - 1'b1;
            end

            if (wdog_expired) begin
                state_r       <= IDLE;
                frame_error_o <= 1'b1;
            end else if (fall_r) begin
                case (state_r)
                    IDLE: begin
                        // start bit must be low
                        if (!data_r) begin
                            state_r      <= DATA;
                            bit_cnt_r    <= '0;
                            parity_acc_r <= 1'b0;
                        end
                    end
                    DATA: begin
                        parity_acc_r <= parity_acc_r ^ data_r;
                        bit_cnt_r    <= bit_cnt_r + 1'b1;
                        if (bit_cnt_r == 3'd7) begin
                            state_r <= PARITY;
                        end
                    end
                    PARITY: begin
                        // odd parity over data plus parity bit
                        parity_ok_r <= parity_acc_r ^ data_r;
                        state_r     <= STOP;
                    end
                    STOP: begin
                        if (parity_ok_r && data_r) begin
                            ready_o <= 1'b1;
                        end else begin
                            frame_error_o <= 1'b1;
                        end
                        state_r <= IDLE;
                    end
                    default: state_r <= IDLE;
                endcase
            end
        end
    end

    // lsb first, so shift in from the top
    always_ff @(posedge clk_i) begin
        if (fall_r && state_r == DATA) begin
            shift_r <= {data_r, shift_r[7:1]};
        end
        if (fall_r && state_r == STOP) begin
            scancode_o <= shift_r;
        end
    end

endmodule

/* rtl/scancode_decoder.sv */
module scancode_decoder (
    input  logic               clk_i,
    input  logic               reset_i,
    input  logic               ready_i,
    input  common::scancode_t  scancode_i,
    input  logic               frame_error_i,
    output logic               event_valid_o,
    output common::key_event_t event_o
);
    import common::*;

    dec_state_t state_r;
    logic       ext_pend_r;
    logic       rel_pend_r;
    logic       is_prefix;
    logic       emit;

    assign is_prefix = (scancode_i == PREFIX_EXTENDED) || (scancode_i == PREFIX_RELEASE);
    assign emit      = ready_i && !is_prefix;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_r       <= WAIT_CODE;
            ext_pend_r    <= 1'b0;
            rel_pend_r    <= 1'b0;
            event_valid_o <= 1'b0;
        end else begin
            event_valid_o <= emit;

            if (frame_error_i) begin
                // a broken sequence must not tag the next key
                state_r    <= WAIT_CODE;
                ext_pend_r <= 1'b0;
                rel_pend_r <= 1'b0;
            end else if (ready_i) begin
                if (scancode_i == PREFIX_EXTENDED) begin
                    ext_pend_r <= 1'b1;
                    state_r    <= AFTER_PREFIX;
                end else if (scancode_i == PREFIX_RELEASE) begin
                    rel_pend_r <= 1'b1;
                    state_r    <= AFTER_PREFIX;
                end else begin
                    ext_pend_r <= 1'b0;
                    rel_pend_r <= 1'b0;
                    state_r    <= WAIT_CODE;
                end
            end
        end
    end

    // flags only count when a prefix was actually seen
    always_ff @(posedge clk_i) begin
        if (emit) begin
            event_o <= {(state_r == AFTER_PREFIX) && ext_pend_r,
                        (state_r == AFTER_PREFIX) && rel_pend_r,
                        scancode_i};
        end
    end

endmodule

/* run_sim.sh */
#!/bin/sh
# build the testbench with Verilator, run it, and check the log

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
    --top-module tb_kbd_subsystem \
    -f kbd_subsystem.f \
    -o tb_kbd_subsystem \
    && ./obj_dir/tb_kbd_subsystem > sim.log 2>&1

# the log decides the result
grep -q "Test passed" sim.log \
    && echo "simulation ok" \
    || { echo "simulation did not pass, see sim.log"; exit 1; }

/* sim/ps2_device.sv */
module ps2_device #(
    parameter int HALF_PERIOD = 20
) (
    input  logic clk_i,
    output logic ps2_clk_o,
    output logic ps2_data_o
);
    import common::*;

    // both lines released high
    task automatic go_idle();
        ps2_clk_o  = 1'b1;
        ps2_data_o = 1'b1;
    endtask

    // data set up while the clock is high, sampled on the falling edge
    task automatic clock_bit(input logic value);
        @(negedge clk_i);
        ps2_data_o = value;
        repeat (HALF_PERIOD) @(negedge clk_i);
        ps2_clk_o = 1'b0;
        repeat (HALF_PERIOD) @(negedge clk_i);
        ps2_clk_o = 1'b1;
    endtask

    // frame bits from lsb: start, data lsb first, odd parity, stop
    task automatic send_frame(input scancode_t code, input logic flip_parity,
                              input logic stop_value, input int nbits);
        logic [10:0] frame;
        frame = {stop_value, ~(^code) ^ flip_parity, code, 1'b0};
        for (int i = 0; i < nbits; i++) begin
            clock_bit(frame[i]);
        end
        ps2_data_o = 1'b1;
        // idle gap before the next frame
        repeat (2 * HALF_PERIOD) @(negedge clk_i);
    endtask

    task automatic send_byte(input scancode_t code);
        send_frame(code, 1'b0, 1'b1, 11);
    endtask

    task automatic send_bad_parity(input scancode_t code);
        send_frame(code, 1'b1, 1'b1, 11);
    endtask

    task automatic send_bad_stop(input scancode_t code);
        send_frame(code, 1'b0, 1'b0, 11);
    endtask

    // device stops clocking after nbits bits
    task automatic send_truncated(input scancode_t code, input int nbits);
        send_frame(code, 1'b0, 1'b1, nbits);
    endtask

endmodule

/* sim/tb_kbd_subsystem.sv */
module tb_kbd_subsystem;
    import common::*;

    localparam int HALF_BIT_CYCLES = 20;
    localparam int EVENT_TIMEOUT   = 2000;
    localparam int STALL_TIMEOUT   = 4 * WATCHDOG_CYCLES;
    localparam int SEED            = 41523;

    logic       clk;
    logic       reset;
    logic       ps2_clk;
    logic       ps2_data;
    logic       pop;
    logic       event_valid;
    key_event_t key_event;
    logic       overflow;
    logic       frame_error;

    key_event_t expected_q[$];
    int         fail_count;
    int         test_count;
    int         frame_err_seen;
    int         ovf_fall_errs;
    int         err_push_errs;

    kbd_subsystem u_dut (
        .clk_i         (clk),
        .reset_i       (reset),
        .ps2_clk_i     (ps2_clk),
        .ps2_data_i    (ps2_data),
        .pop_i         (pop),
        .event_valid_o (event_valid),
        .event_o       (key_event),
        .overflow_o    (overflow),
        .frame_error_o (frame_error)
    );

    ps2_device #(.HALF_PERIOD(HALF_BIT_CYCLES)) u_dev (
        .clk_i      (clk),
        .ps2_clk_o  (ps2_clk),
        .ps2_data_o (ps2_data)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        if (!reset && frame_error) begin
            frame_err_seen <= frame_err_seen + 1;
        end
    end

    // overflow is sticky until reset
    overflow_sticky: assert property (@(posedge clk) disable iff (reset) !$fell(overflow))
        else begin
            $display("Fail at %0t: overflow flag dropped outside reset", $time);
            ovf_fall_errs++;
        end

    error_without_push: assert property (@(posedge clk) disable iff (reset)
        !(frame_error && u_dut.dec_valid && !event_valid))
        else begin
            $display("Fail at %0t: frame error together with a push on an empty queue", $time);
            err_push_errs++;
        end

    function automatic int total_errors();
        return fail_count + ovf_fall_errs + err_push_errs;
    endfunction

    function automatic key_event_t make_event(input logic ext, input logic rel,
                                              input scancode_t code);
        return {ext, rel, code};
    endfunction

    task automatic check(input logic cond, input string msg);
        assert (cond) else begin
            $display("Fail at %0t: %s", $time, msg);
            fail_count++;
        end
    endtask

    // prefix bytes go out ahead of the code byte
    task automatic send_key(input logic ext, input logic rel, input scancode_t code);
        if (ext) begin
            u_dev.send_byte(PREFIX_EXTENDED);
        end
        if (rel) begin
            u_dev.send_byte(PREFIX_RELEASE);
        end
        u_dev.send_byte(code);
        expected_q.push_back(make_event(ext, rel, code));
    endtask

    task automatic pop_and_compare(input string tag);
        key_event_t exp_ev;
        int         waited;
        waited = 0;
        while (!event_valid && waited < EVENT_TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (!event_valid) begin
            $display("%s: timed out waiting for a key event", tag);
            fail_count++;
            // the events still queued will not come
            expected_q.delete();
        end else if (expected_q.size() == 0) begin
            $display("%s: a key event arrived that was not expected", tag);
            fail_count++;
        end else begin
            exp_ev = expected_q.pop_front();
            assert (key_event == exp_ev) else begin
                $display("Fail at %0t: %s event %h, expected %h",
                         $time, tag, key_event, exp_ev);
                fail_count++;
            end
            pop = 1'b1;
            @(negedge clk);
            pop = 1'b0;
        end
    endtask

    task automatic drain(input string tag);
        while (expected_q.size() > 0) begin
            pop_and_compare(tag);
        end
    endtask

    task automatic wait_frame_error(input int base, input int limit, input string tag);
        int waited;
        waited = 0;
        while (frame_err_seen == base && waited < limit) begin
            @(negedge clk);
            waited++;
        end
        if (frame_err_seen == base) begin
            $display("%s: timed out waiting for a frame error", tag);
            fail_count++;
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        test_count++;
        if (total_errors() == errors_before) begin
            $display("test %0d %s: ok", test_count, name);
        end else begin
            $display("test %0d %s: %0d errors", test_count, name,
                     total_errors() - errors_before);
        end
    endtask

    initial begin
        int        errors_before;
        int        err_base;
        scancode_t code;
        int        prefix_sel;
        int        threshold;
        void'($urandom(SEED));
        reset = 1'b1;
        pop   = 1'b0;
        u_dev.go_idle();
        repeat (2) @(negedge clk);
        reset = 1'b0;
        @(negedge clk);

        errors_before = total_errors();
        err_base = frame_err_seen;
        send_key(1'b0, 1'b0, 8'h1C);
        pop_and_compare("plain key");
        check(frame_err_seen == err_base, "frame error on a good frame");
        check(!event_valid, "extra event after a plain key");
        report_test("plain key", errors_before);

        errors_before = total_errors();
        send_key(1'b0, 1'b1, 8'h1C);
        pop_and_compare("release");
        check(!event_valid, "extra event after a release sequence");
        send_key(1'b1, 1'b0, 8'h75);
        pop_and_compare("extended");
        check(!event_valid, "extra event after an extended sequence");
        send_key(1'b1, 1'b1, 8'h75);
        pop_and_compare("extended release");
        check(!event_valid, "extra event after an extended release");
        report_test("prefixes", errors_before);

        // the error must drop the pending extended flag
        errors_before = total_errors();
        err_base = frame_err_seen;
        u_dev.send_byte(PREFIX_EXTENDED);
        u_dev.send_bad_parity(8'h3A);
        wait_frame_error(err_base, EVENT_TIMEOUT, "parity error");
        check(!event_valid, "event from a frame with bad parity");
        send_key(1'b0, 1'b0, 8'h1C);
        check(frame_err_seen == err_base + 1, "not exactly one frame error for bad parity");
        pop_and_compare("parity error");
        check(!event_valid, "extra event after the parity error");
        report_test("parity error", errors_before);

        errors_before = total_errors();
        err_base = frame_err_seen;
        u_dev.send_bad_stop(8'h33);
        wait_frame_error(err_base, EVENT_TIMEOUT, "bad stop");
        check(!event_valid, "event from a frame with a bad stop bit");
        err_base = frame_err_seen;
        u_dev.send_truncated(8'h44, 5);
        wait_frame_error(err_base, STALL_TIMEOUT, "stalled frame");
        check(!event_valid, "event from a stalled frame");
        send_key(1'b0, 1'b0, 8'h2A);
        pop_and_compare("stall recovery");
        check(!event_valid, "extra event after stall recovery");
        report_test("stop error and stall", errors_before);

        // only the first FIFO_DEPTH codes fit
        errors_before = total_errors();
        for (int i = 0; i < 10; i++) begin
            code = 8'h10 + 8'(i);
            u_dev.send_byte(code);
            if (i < FIFO_DEPTH) begin
                expected_q.push_back(make_event(1'b0, 1'b0, code));
            end
        end
        check(event_valid, "no event held after the burst");
        check(overflow, "overflow flag not set by a full queue");
        drain("overflow");
        check(!event_valid, "queue not empty after draining");
        report_test("overflow", errors_before);

        errors_before = total_errors();
        threshold = 1 + int'($urandom_range(3));
        for (int n = 0; n < 30; n++) begin
            do begin
                code = 8'($urandom_range(255));
            end while (code == PREFIX_EXTENDED || code == PREFIX_RELEASE);
            prefix_sel = int'($urandom_range(3));
            send_key(prefix_sel[0], prefix_sel[1], code);
            // drain before the queue gets near full
            if (expected_q.size() >= threshold) begin
                drain("random stream");
                threshold = 1 + int'($urandom_range(3));
            end
        end
        drain("random stream");
        check(!event_valid, "queue not empty after the random stream");
        report_test("random stream", errors_before);

        $display("%0d tests run, %0d errors", test_count, total_errors());
        if (total_errors() == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule
